/* Bender.yml */
package:
  name: matmul

sources:
  - common/matmul_pkg.sv
  - hdl/matrix_bram.sv
  - systolic/systolic_pe.sv
  - systolic/systolic_array.sv
  - hdl/tile_sequencer.sv
  - hdl/result_buffer.sv
  - hdl/matmul_top.sv
  - target: simulation
    files:
      - testbench/matmul_checker.sv
      - testbench/tb_matmul.sv

/* all.f */
common/matmul_pkg.sv
hdl/matrix_bram.sv
systolic/systolic_pe.sv
systolic/systolic_array.sv
hdl/tile_sequencer.sv
hdl/result_buffer.sv
hdl/matmul_top.sv
testbench/matmul_checker.sv
testbench/tb_matmul.sv

/* common/matmul_pkg.sv */
// ====================
// Shared types and constants for the systolic matrix multiplier
// Imported by wildcard into every RTL module that needs them
// ====================
`default_nettype none

package matmul_pkg;

    // Fixed-point format, Q7.8
    localparam int ELEM_W = 16;
    localparam int FRAC_W = 8;
    localparam int ACC_W  = 40;     // Headroom for long inner sums
    localparam int IDX_W  = 8;

    typedef logic signed [ELEM_W-1:0] elem_t;   // One matrix element
    typedef logic signed [ACC_W-1:0]  acc_t;    // Raw PE accumulator
    typedef logic        [IDX_W-1:0]  res_idx_t; // Row or column of C

    // Sequencer phases, one pass per output tile
    typedef enum logic [2:0] {
        IDLE,
        LOAD,   // Stream inner dimension
        DRAIN,  // Wait out read latency and skew
        STORE,  // One accumulator per cycle to C
        NEXT    // Clear accumulators, pick next tile
    } seq_state_t;

    // One write into the result buffer
    typedef struct packed {
        logic     en;
        res_idx_t row;
        res_idx_t col;
        acc_t     acc;      // Unscaled sum
    } res_wr_t;

endpackage

`default_nettype wire

/* hdl/matmul_top.sv */
// ====================
// Matrix multiplier top: operand RAMs, systolic array, sequencer, C store
// Load A and B, pulse start, wait for done, read C by address
// ====================
`timescale 1ns/1ps
`default_nettype none

module matmul_top
    import matmul_pkg::*;
#(
    parameter  int BLOCK   = 2,
    parameter  int INNER   = 4,
    parameter  int A_ROWS  = 4,     // Multiple of BLOCK
    parameter  int B_COLS  = 4,     // Multiple of BLOCK
    localparam int A_DEPTH = (A_ROWS / BLOCK) * INNER,
    localparam int B_DEPTH = (B_COLS / BLOCK) * INNER,
    localparam int A_AW    = (A_DEPTH > 1) ? $clog2(A_DEPTH) : 1,
    localparam int B_AW    = (B_DEPTH > 1) ? $clog2(B_DEPTH) : 1,
    localparam int R_AW    = (A_ROWS * B_COLS > 1) ? $clog2(A_ROWS * B_COLS) : 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              a_we,
    input  logic [A_AW-1:0]   a_addr,     // tile_row*INNER + k
    input  elem_t [BLOCK-1:0] a_data,
    input  logic              b_we,
    input  logic [B_AW-1:0]   b_addr,     // tile_col*INNER + k
    input  elem_t [BLOCK-1:0] b_data,
    input  logic              start,
    output logic              busy,
    output logic              done,
    input  logic [R_AW-1:0]   res_addr,
    output elem_t             res_data
);

    logic                    rd_en;
    logic [A_AW-1:0]         a_rd_addr;
    logic [B_AW-1:0]         b_rd_addr;
    elem_t [BLOCK-1:0]       a_rd_data;   // West edge feed
    elem_t [BLOCK-1:0]       b_rd_data;   // North edge feed
    logic                    feed_valid;
    logic                    clear;
    acc_t [BLOCK*BLOCK-1:0]  acc_all;
    res_wr_t                 res_wr;

    matrix_bram #(.DEPTH(A_DEPTH), .BLOCK(BLOCK)) a_mem (
        .clk   (clk),
        .we    (a_we),
        .waddr (a_addr),
        .wdata (a_data),
        .rd_en (rd_en),
        .raddr (a_rd_addr),
        .rdata (a_rd_data)
    );

    matrix_bram #(.DEPTH(B_DEPTH), .BLOCK(BLOCK)) b_mem (
        .clk   (clk),
        .we    (b_we),
        .waddr (b_addr),
        .wdata (b_data),
        .rd_en (rd_en),
        .raddr (b_rd_addr),
        .rdata (b_rd_data)
    );

    systolic_array #(.BLOCK(BLOCK)) u_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .feed_valid (feed_valid),
        .a_col      (a_rd_data),
        .b_row      (b_rd_data),
        .acc_all    (acc_all)
    );

    tile_sequencer #(
        .BLOCK  (BLOCK),
        .INNER  (INNER),
        .A_ROWS (A_ROWS),
        .B_COLS (B_COLS)
    ) u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .rd_en      (rd_en),
        .a_rd_addr  (a_rd_addr),
        .b_rd_addr  (b_rd_addr),
        .feed_valid (feed_valid),
        .clear      (clear),
        .acc_all    (acc_all),
        .res_wr     (res_wr)
    );

    result_buffer #(.A_ROWS(A_ROWS), .B_COLS(B_COLS)) u_res (
        .clk      (clk),
        .res_wr   (res_wr),
        .res_addr (res_addr),
        .res_data (res_data)
    );

endmodule

`default_nettype wire

/* hdl/matrix_bram.sv */
// ====================
// Simple dual-port RAM for operand storage, one block row/col per word
// Host writes on one port, sequencer reads on the other
// ====================
`timescale 1ns/1ps
`default_nettype none

module matrix_bram
    import matmul_pkg::*;
#(
    parameter  int DEPTH = 8,
    parameter  int BLOCK = 2,
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic              clk,
    input  logic              we,
    input  logic [AW-1:0]     waddr,
    input  elem_t [BLOCK-1:0] wdata,
    input  logic              rd_en,
    input  logic [AW-1:0]     raddr,
    output elem_t [BLOCK-1:0] rdata
);

    elem_t [BLOCK-1:0] mem [DEPTH];     // Inferred, no init

    // Host write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, output holds while idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[raddr];        // Old data on same-address collision
        end
    end

endmodule

`default_nettype wire

/* hdl/result_buffer.sv */
// ====================
// Full C matrix store, rescale and clamp on write
// Host reads by row*B_COLS+col, data one cycle later
// ====================
`timescale 1ns/1ps
`default_nettype none

module result_buffer
    import matmul_pkg::*;
#(
    parameter  int A_ROWS = 4,
    parameter  int B_COLS = 4,
    localparam int DEPTH  = A_ROWS * B_COLS,
    localparam int R_AW   = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic            clk,
    input  res_wr_t         res_wr,
    input  logic [R_AW-1:0] res_addr,
    output elem_t           res_data
);

    // Clamp limits of elem_t, widened to accumulator size
    localparam acc_t SAT_HI = acc_t'((1 << (ELEM_W - 1)) - 1);
    localparam acc_t SAT_LO = acc_t'(-(1 << (ELEM_W - 1)));

    elem_t           mem [DEPTH];
    acc_t            scaled;
    elem_t           sat_val;
    logic [R_AW-1:0] waddr;

    assign scaled = res_wr.acc >>> FRAC_W;     // Drop product fraction, floor
    assign waddr  = R_AW'(res_wr.row * B_COLS + res_wr.col);

    // Saturate to Q7.8
    always_comb begin
        if (scaled > SAT_HI) begin
            sat_val = elem_t'(SAT_HI);
        end else if (scaled < SAT_LO) begin
            sat_val = elem_t'(SAT_LO);
        end else begin
            sat_val = elem_t'(scaled);          // Fits, plain truncation
        end
    end

    always_ff @(posedge clk) begin
        if (res_wr.en) begin
            mem[waddr] <= sat_val;
        end
    end

    // Host read port, always enabled
    always_ff @(posedge clk) begin
        res_data <= mem[res_addr];
    end

endmodule

`default_nettype wire

/* hdl/tile_sequencer.sv */
// ====================
// Walks output tiles through LOAD, DRAIN, STORE and NEXT
// Tiles go row-major with tile_col fastest
// ====================
`timescale 1ns/1ps
`default_nettype none

module tile_sequencer
    import matmul_pkg::*;
#(
    parameter  int BLOCK     = 2,
    parameter  int INNER     = 4,
    parameter  int A_ROWS    = 4,
    parameter  int B_COLS    = 4,
    localparam int TILE_ROWS = A_ROWS / BLOCK,
    localparam int TILE_COLS = B_COLS / BLOCK,
    localparam int A_DEPTH   = TILE_ROWS * INNER,
    localparam int B_DEPTH   = TILE_COLS * INNER,
    localparam int A_AW      = (A_DEPTH > 1) ? $clog2(A_DEPTH) : 1,
    localparam int B_AW      = (B_DEPTH > 1) ? $clog2(B_DEPTH) : 1
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    output logic                    busy,
    output logic                    done,
    output logic                    rd_en,
    output logic [A_AW-1:0]         a_rd_addr,
    output logic [B_AW-1:0]         b_rd_addr,
    output logic                    feed_valid,
    output logic                    clear,
    input  acc_t [BLOCK*BLOCK-1:0]  acc_all,
    output res_wr_t                 res_wr
);

    // Counter widths with +1 to stay nonzero for size 1
    localparam int K_W  = $clog2(INNER + 1);
    localparam int D_W  = $clog2(2 * BLOCK + 1);
    localparam int E_W  = $clog2(BLOCK * BLOCK + 1);
    localparam int TR_W = $clog2(TILE_ROWS + 1);
    localparam int TC_W = $clog2(TILE_COLS + 1);

    seq_state_t      state;
    logic [K_W-1:0]  k_cnt;
    logic [D_W-1:0]  drain_cnt;
    logic [E_W-1:0]  st_cnt;        // Element within tile
    logic [TR_W-1:0] tile_row;
    logic [TC_W-1:0] tile_col;

    logic last_k, last_drain, last_st, last_tile;

    assign last_k     = (k_cnt == K_W'(INNER - 1));
    assign last_drain = (drain_cnt == D_W'(2 * BLOCK - 1));
    assign last_st    = (st_cnt == E_W'(BLOCK * BLOCK - 1));
    assign last_tile  = (tile_row == TR_W'(TILE_ROWS - 1)) &&
                        (tile_col == TC_W'(TILE_COLS - 1));

    // Memory reads straight from LOAD with data back next cycle
    assign rd_en     = (state == LOAD);
    assign a_rd_addr = A_AW'(tile_row * INNER + k_cnt);
    assign b_rd_addr = B_AW'(tile_col * INNER + k_cnt);
    assign clear     = (state == NEXT);     // Acc zero on NEXT edge
    assign busy      = (state != IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            k_cnt     <= '0;
            drain_cnt <= '0;
            st_cnt    <= '0;
            tile_row  <= '0;
            tile_col  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin            // Start ignored once busy
                        state    <= LOAD;
                        k_cnt    <= '0;
                        tile_row <= '0;
                        tile_col <= '0;
                    end
                end
                LOAD: begin
                    k_cnt <= k_cnt + 1'b1;
                    if (last_k) begin
                        state     <= DRAIN;
                        drain_cnt <= '0;
                    end
                end
                DRAIN: begin
                    drain_cnt <= drain_cnt + 1'b1;
                    if (last_drain) begin       // Last PE settled by now
                        state  <= STORE;
                        st_cnt <= '0;
                    end
                end
                STORE: begin
                    st_cnt <= st_cnt + 1'b1;
                    if (last_st) begin
                        state <= NEXT;
                    end
                end
                NEXT: begin
                    k_cnt <= '0;
                    if (last_tile) begin
                        state <= IDLE;
                    end else begin
                        state <= LOAD;
                        if (tile_col == TC_W'(TILE_COLS - 1)) begin
                            tile_col <= '0;
                            tile_row <= tile_row + 1'b1;
                        end else begin
                            tile_col <= tile_col + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Control pulses, delayed feed strobe and store payload
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            feed_valid <= 1'b0;
            done       <= 1'b0;
            res_wr.en  <= 1'b0;
        end else begin
            feed_valid <= rd_en;        // Aligned with rdata
            done       <= (state == STORE) && last_st && last_tile;
            res_wr.en  <= (state == STORE);
        end
        // One accumulator per cycle with its absolute position
        res_wr.row <= res_idx_t'(tile_row * BLOCK + st_cnt / BLOCK);
        res_wr.col <= res_idx_t'(tile_col * BLOCK + st_cnt % BLOCK);
        res_wr.acc <= acc_all[st_cnt];
    end

endmodule

`default_nettype wire

/* systolic/systolic_array.sv */
// ====================
// BLOCK x BLOCK grid of PEs with skewed west and north inputs
// Accumulators exposed flat, index row*BLOCK+col
// ====================
`timescale 1ns/1ps
`default_nettype none

module systolic_array
    import matmul_pkg::*;
#(
    parameter int BLOCK = 2
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     clear,
    input  logic                     feed_valid,
    input  elem_t [BLOCK-1:0]        a_col,     // Column k of A block
    input  elem_t [BLOCK-1:0]        b_row,     // Row k of B block
    output acc_t  [BLOCK*BLOCK-1:0]  acc_all
);

    // Links between PEs, one extra slot at the far edges
    elem_t a_h [BLOCK][BLOCK+1];    // West to east
    logic  v_h [BLOCK][BLOCK+1];    // Valid rides with A
    elem_t b_v [BLOCK+1][BLOCK];    // North to south

    genvar i, j;

    // Edge skew, lane i delayed by i cycles
    for (i = 0; i < BLOCK; i++) begin : g_skew
        if (i == 0) begin : g_direct
            assign a_h[0][0] = a_col[0];
            assign v_h[0][0] = feed_valid;
            assign b_v[0][0] = b_row[0];
        end else begin : g_delay
            elem_t a_sr [i];
            elem_t b_sr [i];
            logic  v_sr [i];

            always_ff @(posedge clk) begin
                a_sr[0] <= a_col[i];
                b_sr[0] <= b_row[i];
                for (int d = 1; d < i; d++) begin
                    a_sr[d] <= a_sr[d-1];
                    b_sr[d] <= b_sr[d-1];
                end
            end

            // Valid lane gets a reset, data lanes do not
            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    for (int d = 0; d < i; d++) begin
                        v_sr[d] <= 1'b0;
                    end
                end else begin
                    v_sr[0] <= feed_valid;
                    for (int d = 1; d < i; d++) begin
                        v_sr[d] <= v_sr[d-1];
                    end
                end
            end

            assign a_h[i][0] = a_sr[i-1];   // Row i enters late by i
            assign v_h[i][0] = v_sr[i-1];
            assign b_v[0][i] = b_sr[i-1];   // Column i enters late by i
        end
    end

    // PE grid, A and B for step k meet at PE(i,j) after i+j cycles
    for (i = 0; i < BLOCK; i++) begin : g_row
        for (j = 0; j < BLOCK; j++) begin : g_col
            systolic_pe u_pe (
                .clk       (clk),
                .rst_n     (rst_n),
                .clear     (clear),
                .valid_in  (v_h[i][j]),
                .a_in      (a_h[i][j]),
                .b_in      (b_v[i][j]),
                .valid_out (v_h[i][j+1]),
                .a_out     (a_h[i][j+1]),
                .b_out     (b_v[i+1][j]),
                .acc       (acc_all[i*BLOCK+j])
            );
        end
    end

endmodule

`default_nettype wire

/* systolic/systolic_pe.sv */
// ====================
// Output-stationary PE: multiply, accumulate, pass operands east/south
// ====================
`timescale 1ns/1ps
`default_nettype none

module systolic_pe
    import matmul_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clear,
    input  logic  valid_in,
    input  elem_t a_in,
    input  elem_t b_in,
    output logic  valid_out,
    output elem_t a_out,
    output elem_t b_out,
    output acc_t  acc
);

    logic signed [2*ELEM_W-1:0] prod;   // Q14.16, rescaled later in buffer

    assign prod = a_in * b_in;

    // Accumulator and valid chain
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc       <= '0;
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
            if (clear) begin
                acc <= '0;                      // Clear wins over a late pair
            end else if (valid_in) begin
                acc <= acc + acc_t'(prod);      // Sign extended
            end
        end
    end

    // Operand forwarding to neighbours
    always_ff @(posedge clk) begin
        a_out <= a_in;  // East
        b_out <= b_in;  // South
    end

endmodule

`default_nettype wire

/* testbench/matmul_checker.sv */
// ====================
// Testbench checker: rebuilds A and B from host writes, models C, compares reads
// Test framing and level checks are called from the testbench top
// ====================
`timescale 1ns/1ps
`default_nettype none

module matmul_checker
    import matmul_pkg::*;
#(
    parameter  int BLOCK  = 2,
    parameter  int INNER  = 4,
    parameter  int A_ROWS = 4,
    parameter  int B_COLS = 4,
    localparam int A_AW   = ((A_ROWS / BLOCK) * INNER > 1) ? $clog2((A_ROWS / BLOCK) * INNER) : 1,
    localparam int B_AW   = ((B_COLS / BLOCK) * INNER > 1) ? $clog2((B_COLS / BLOCK) * INNER) : 1,
    localparam int R_AW   = (A_ROWS * B_COLS > 1) ? $clog2(A_ROWS * B_COLS) : 1
) (
    input  logic              clk,
    input  logic              a_we,
    input  logic [A_AW-1:0]   a_addr,
    input  elem_t [BLOCK-1:0] a_data,
    input  logic              b_we,
    input  logic [B_AW-1:0]   b_addr,
    input  elem_t [BLOCK-1:0] b_data,
    input  logic              rd_check,   // res_addr is a read to compare
    input  logic [R_AW-1:0]   res_addr,
    input  elem_t             res_data,
    output int                tests_run,
    output int                tests_failed,
    output int                error_count,
    output int                check_count
);

    logic signed [15:0] a_mat [A_ROWS][INNER];     // Model copy of A
    logic signed [15:0] b_mat [INNER][B_COLS];     // Model copy of B

    string           cur_test = "none";
    int              test_errs = 0;
    int              test_checks = 0;
    int              n_tests = 0;
    int              n_failed = 0;
    int              n_errors = 0;
    int              n_checks = 0;
    logic            pend_valid = 1'b0;  // Read issued, data due next cycle
    logic [R_AW-1:0] pend_addr = '0;
    int              exp_val;

    assign tests_run    = n_tests;
    assign tests_failed = n_failed;
    assign error_count  = n_errors;
    assign check_count  = n_checks;

    // C element: exact sum, drop 8 fraction bits (floor), clamp to 16 bits
    function automatic int expected_elem(input int row, input int col);
        longint sum;
        sum = 0;
        for (int k = 0; k < INNER; k++) begin
            sum += longint'(a_mat[row][k]) * longint'(b_mat[k][col]);
        end
        sum = sum >>> 8;
        if (sum > 32767) return 32767;
        if (sum < -32768) return -32768;
        return int'(sum);
    endfunction

    task automatic test_begin(input string name);
        cur_test    = name;
        test_errs   = 0;
        test_checks = 0;
    endtask

    task automatic test_end();
        n_tests++;
        if (test_errs == 0) begin
            $display("test %s: ok, %0d checks", cur_test, test_checks);
        end else begin
            n_failed++;
            $display("test %s: %0d of %0d checks wrong", cur_test, test_errs, test_checks);
        end
    endtask

    task automatic expect_level(input string what, input int exp, input int act);
        test_checks++;
        n_checks++;
        if (act != exp) begin
            $display("error %s %s expected %0d actual %0d", cur_test, what, exp, act);
            test_errs++;
            n_errors++;
        end
    endtask

    // Failures that have no value to compare
    task automatic report_fault(input string what);
        $display("test %s: %s", cur_test, what);
        test_errs++;
        n_errors++;
    endtask

    // Host writes, sampled mid-cycle when stable
    always @(negedge clk) begin
        for (int r = 0; r < BLOCK; r++) begin
            if (a_we) a_mat[(a_addr / INNER) * BLOCK + r][a_addr % INNER] = a_data[r];
            if (b_we) b_mat[b_addr % INNER][(b_addr / INNER) * BLOCK + r] = b_data[r];
        end
    end

    // Read compare, data one cycle behind the address
    always @(negedge clk) begin
        if (pend_valid) begin
            exp_val = expected_elem(pend_addr / B_COLS, pend_addr % B_COLS);
            test_checks++;
            n_checks++;
            if (res_data !== 16'(exp_val)) begin
                $display("error %s C[%0d][%0d] expected %0d actual %0d", cur_test,
                         pend_addr / B_COLS, pend_addr % B_COLS, exp_val, res_data);
                test_errs++;
                n_errors++;
            end
        end
        pend_valid = rd_check;
        pend_addr  = res_addr;
    end

endmodule

`default_nettype wire

/* testbench/tb_matmul.sv */
// ====================
// Drives clock, reset, operand loading, runs and C readback
// Comparison happens in matmul_checker
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_matmul
    import matmul_pkg::*;
();

    localparam int BLOCK  = 2;
    localparam int INNER  = 4;
    localparam int A_ROWS = 4;
    localparam int B_COLS = 4;
    localparam int A_DEPTH = (A_ROWS / BLOCK) * INNER;
    localparam int B_DEPTH = (B_COLS / BLOCK) * INNER;
    localparam int A_AW = (A_DEPTH > 1) ? $clog2(A_DEPTH) : 1;
    localparam int B_AW = (B_DEPTH > 1) ? $clog2(B_DEPTH) : 1;
    localparam int R_AW = (A_ROWS * B_COLS > 1) ? $clog2(A_ROWS * B_COLS) : 1;

    // Cycles per tile for load, drain, store and next
    localparam int TILE_CYCLES = INNER + 2 * BLOCK + BLOCK * BLOCK + 1;
    localparam int NUM_TILES   = (A_ROWS / BLOCK) * (B_COLS / BLOCK);
    localparam int RUN_CYCLES  = TILE_CYCLES * NUM_TILES;
    localparam int RUN_TIMEOUT = RUN_CYCLES + 20;
    localparam int NUM_TESTS   = 5;
    localparam int MARGIN      = 4 * NUM_TESTS * (A_DEPTH + B_DEPTH + A_ROWS * B_COLS + RUN_CYCLES);
    localparam int WATCHDOG_CYCLES = NUM_TESTS * RUN_CYCLES + MARGIN;

    logic              clk, rst_n, start, busy, done;
    logic              a_we, b_we, rd_check;
    logic [A_AW-1:0]   a_addr;
    logic [B_AW-1:0]   b_addr;
    elem_t [BLOCK-1:0] a_data, b_data;
    logic [R_AW-1:0]   res_addr;
    elem_t             res_data;
    int                tests_run, tests_failed, error_count, check_count;
    int                a_val [A_ROWS][INNER];    // Stimulus matrices
    int                b_val [INNER][B_COLS];
    integer            seed;

    matmul_top #(.BLOCK(BLOCK), .INNER(INNER), .A_ROWS(A_ROWS), .B_COLS(B_COLS)) dut (
        .clk(clk), .rst_n(rst_n),
        .a_we(a_we), .a_addr(a_addr), .a_data(a_data),
        .b_we(b_we), .b_addr(b_addr), .b_data(b_data),
        .start(start), .busy(busy), .done(done),
        .res_addr(res_addr), .res_data(res_data)
    );

    matmul_checker #(.BLOCK(BLOCK), .INNER(INNER), .A_ROWS(A_ROWS), .B_COLS(B_COLS)) u_checker (
        .clk(clk),
        .a_we(a_we), .a_addr(a_addr), .a_data(a_data),
        .b_we(b_we), .b_addr(b_addr), .b_data(b_data),
        .rd_check(rd_check), .res_addr(res_addr), .res_data(res_data),
        .tests_run(tests_run), .tests_failed(tests_failed),
        .error_count(error_count), .check_count(check_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    task automatic reset_dut();
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    // Each A word holds BLOCK rows of column k
    // Each B word holds BLOCK columns of row k
    task automatic load_operands();
        for (int t = 0; t < A_ROWS / BLOCK; t++) begin
            for (int k = 0; k < INNER; k++) begin
                @(posedge clk);
                #1;
                a_we   = 1'b1;
                a_addr = A_AW'(t * INNER + k);
                for (int r = 0; r < BLOCK; r++) a_data[r] = elem_t'(a_val[t * BLOCK + r][k]);
            end
        end
        for (int t = 0; t < B_COLS / BLOCK; t++) begin
            for (int k = 0; k < INNER; k++) begin
                @(posedge clk);
                #1;
                a_we   = 1'b0;
                b_we   = 1'b1;
                b_addr = B_AW'(t * INNER + k);
                for (int c = 0; c < BLOCK; c++) b_data[c] = elem_t'(b_val[k][t * BLOCK + c]);
            end
        end
        @(posedge clk);
        #1;
        b_we = 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_done(output bit seen);
        int n;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < RUN_TIMEOUT) begin
            @(negedge clk);
            seen = done;
            n++;
        end
    endtask

    // Read every C element at one address per cycle
    task automatic read_all();
        for (int a = 0; a < A_ROWS * B_COLS; a++) begin
            @(posedge clk);
            #1;
            res_addr = R_AW'(a);
            rd_check = 1'b1;
        end
        @(posedge clk);
        #1;
        rd_check = 1'b0;
        @(negedge clk);     // Last compare lands here
        #1;
    endtask

    task automatic run_once();
        bit seen;
        load_operands();
        pulse_start();
        wait_done(seen);
        if (seen) begin
            read_all();
        end else begin
            u_checker.report_fault("done never arrived after start");
        end
    endtask

    task automatic run_test(input string name);
        u_checker.test_begin(name);
        run_once();
        u_checker.test_end();
    endtask

    task automatic fill_identity();
        for (int i = 0; i < A_ROWS; i++)
            for (int k = 0; k < INNER; k++) a_val[i][k] = (i == k) ? 256 : 0;   // 1.0
        for (int k = 0; k < INNER; k++)
            for (int j = 0; j < B_COLS; j++) b_val[k][j] = $random(seed) % 32768;
    endtask

    task automatic fill_small();
        for (int i = 0; i < A_ROWS; i++)
            for (int k = 0; k < INNER; k++) a_val[i][k] = $random(seed) % 513;   // +-2.0
        for (int k = 0; k < INNER; k++)
            for (int j = 0; j < B_COLS; j++) b_val[k][j] = $random(seed) % 513;
    endtask

    // Rows split by sign, columns alternate sign, last column stays in range
    task automatic fill_saturation();
        for (int i = 0; i < A_ROWS; i++)
            for (int k = 0; k < INNER; k++) a_val[i][k] = (i < A_ROWS / 2) ? 24576 : -24576;
        for (int k = 0; k < INNER; k++)
            for (int j = 0; j < B_COLS; j++)
                b_val[k][j] = (j == B_COLS - 1) ? 1 : ((j % 2 == 0) ? 20480 : -20480);
    endtask

    task automatic control_levels();
        int cyc, dones;
        bit busy_held, idle_after, prev_done;
        u_checker.test_begin("control levels");
        fill_small();
        @(posedge clk);
        #1;
        reset_dut();
        @(negedge clk);
        u_checker.expect_level("busy after reset", 0, busy);
        u_checker.expect_level("done after reset", 0, done);
        load_operands();
        pulse_start();
        @(negedge clk);
        u_checker.expect_level("busy after start", 1, busy);
        cyc = 0;
        dones = 0;
        busy_held = 1'b1;
        idle_after = 1'b1;
        prev_done = 1'b0;
        while (cyc < 2 * RUN_TIMEOUT) begin
            @(posedge clk);
            #1;
            start = (cyc == 3);                 // Stray start while busy
            @(negedge clk);
            if (prev_done && busy) idle_after = 1'b0;
            if (dones == 0 && !busy) busy_held = 1'b0;
            prev_done = done;
            if (done) dones++;
            cyc++;
        end
        if (dones == 0) begin
            u_checker.report_fault("done never pulsed after start");
        end else begin
            u_checker.expect_level("done pulses per start", 1, dones);
            u_checker.expect_level("busy held until done", 1, busy_held);
            u_checker.expect_level("busy low after done", 1, idle_after);
            read_all();
        end
        u_checker.test_end();
    endtask

    initial begin
        seed = 32'hbd1aa080;
        rst_n = 1'b0;
        start = 1'b0;
        a_we = 1'b0;
        b_we = 1'b0;
        a_addr = '0;
        b_addr = '0;
        a_data = '0;
        b_data = '0;
        res_addr = '0;
        rd_check = 1'b0;
        reset_dut();
        fill_identity();
        run_test("identity");
        fill_small();
        run_test("random small");
        fill_saturation();
        run_test("saturation");
        u_checker.test_begin("back-to-back");
        fill_small();
        run_once();
        fill_small();                           // Fresh operands for the second start
        run_once();
        u_checker.test_end();
        control_levels();
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
